// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the trace unit testbench with Verilator, runs it and checks the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_trace_top -o tb_trace_top

sim_out=$(./obj_dir/tb_trace_top)
echo "$sim_out"

if grep -q "^Done: no errors$" <<< "$sim_out"; then
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim.f ====
+incdir+.
trace_pkg.sv
trace_record_fifo.sv
trace_loss_counter.sv
trace_emit_fsm.sv
trace_packer.sv
trace_top.sv
tb_trace_top.sv

// ==== tb_trace_tasks.svh ====
// Directed tests for the retirement trace unit
// Record driving, expected packet building and stream comparison

// mem_kind 0 is no access, 1 a load, 2 a store
function automatic tb_rec_t make_rec(input trace_pkg::order_t ord,
                                     input trace_pkg::reg_addr_t rd,
                                     input int unsigned mem_kind, input logic trap);
  tb_rec_t r;
  r.order    = ord;
  r.insn     = 32'h0000_0013 ^ {ord[15:0], 16'h0000};
  r.trap     = trap;
  r.rd_addr  = rd;
  r.rd_wdata = 32'hd000_0000 + ord[31:0];
  r.pc       = 32'h8000_0000 + {ord[29:0], 2'b00};
  r.mem_addr = 32'h2000_0100 + {ord[29:0], 2'b00};
  r.rmask    = (mem_kind == 1) ? 4'hf : 4'h0;
  r.wmask    = (mem_kind == 2) ? 4'h3 : 4'h0;
  return r;
endfunction

task automatic set_record(input tb_rec_t r);
  rvfi_valid_i     <= 1'b1;
  rvfi_order_i     <= r.order;
  rvfi_insn_i      <= r.insn;
  rvfi_trap_i      <= r.trap;
  rvfi_rd_addr_i   <= r.rd_addr;
  rvfi_rd_wdata_i  <= r.rd_wdata;
  rvfi_pc_rdata_i  <= r.pc;
  rvfi_mem_addr_i  <= r.mem_addr;
  rvfi_mem_rmask_i <= r.rmask;
  rvfi_mem_wmask_i <= r.wmask;
endtask

task automatic drive_record(input tb_rec_t r);
  @(posedge clk_i);
  set_record(r);
endtask

task automatic end_records();
  @(posedge clk_i);
  rvfi_valid_i <= 1'b0;
endtask

// Header, pc, insn, then rd_wdata and mem_addr when present
task automatic add_expected(input tb_rec_t r);
  trace_pkg::word_t head;
  logic             has_rd;
  logic             has_mem;
  has_rd       = (r.rd_addr != 5'd0);
  has_mem      = ((r.rmask | r.wmask) != 4'h0);
  head         = 32'h0;
  head[31:28]  = 4'h1;
  head[27]     = r.trap;
  head[26]     = has_rd;
  head[25]     = has_mem;
  head[24]     = (r.wmask != 4'h0);
  head[20:16]  = r.rd_addr;
  head[15:0]   = r.order[15:0];
  exp_q.push_back(head);
  exp_q.push_back(r.pc);
  exp_q.push_back(r.insn);
  if (has_rd) begin
    exp_q.push_back(r.rd_wdata);
  end
  if (has_mem) begin
    exp_q.push_back(r.mem_addr);
  end
endtask

task automatic add_expected_loss(input logic [7:0] cnt);
  trace_pkg::word_t w;
  w        = 32'h0;
  w[31:28] = 4'h2;
  w[7:0]   = cnt;
  exp_q.push_back(w);
endtask

task automatic wait_words(input int n, input int unsigned limit);
  int unsigned cyc;
  cyc = 0;
  while ((got_q.size() < n) && (cyc < limit)) begin
    @(negedge clk_i);
    cyc++;
  end
  if (got_q.size() < n) begin
    $display("Timeout: only %0d of %0d trace words arrived within %0d cycles",
             got_q.size(), n, limit);
    errors++;
  end
endtask

task automatic check_stream(input string name);
  int n;
  int i;
  n = exp_q.size();
  wait_words(n, 600);
  // Idle cycles so that surplus words would show up
  repeat (5) @(negedge clk_i);
  checks++;
  if (got_q.size() != n) begin
    $display("ERROR @%0t: %s got %0d words, expected %0d", $time, name, got_q.size(), n);
    errors++;
  end
  for (i = 0; (i < n) && (i < got_q.size()); i++) begin
    checks++;
    if (got_q[i] !== exp_q[i]) begin
      $display("ERROR @%0t: %s word %0d is %08h, expected %08h",
               $time, name, i, got_q[i], exp_q[i]);
      errors++;
    end
  end
  got_q.delete();
  exp_q.delete();
endtask

task automatic quiet_after_reset();
  int i;
  for (i = 0; i < 7; i++) begin
    @(posedge clk_i);
    if (i == 3) begin
      rst_n_i <= 1'b1;
    end
    checks++;
    if (trace_valid_o !== 1'b0) begin
      $display("ERROR @%0t: trace_valid_o high during or after reset", $time);
      errors++;
    end
  end
  checks++;
  if (got_q.size() != 0) begin
    $display("ERROR @%0t: %0d words collected before any record", $time, got_q.size());
    errors++;
  end
endtask

task automatic single_rd_packet();
  tb_rec_t r;
  r = make_rec(64'h0000_0003_0000_1a2b, 5'd10, 0, 1'b0);
  drive_record(r);
  end_records();
  add_expected(r);
  check_stream("single rd record");
endtask

task automatic store_load_packets();
  tb_rec_t st;
  tb_rec_t ld;
  st = make_rec(64'd77, 5'd0, 2, 1'b1);
  ld = make_rec(64'd78, 5'd7, 1, 1'b0);
  drive_record(st);
  end_records();
  add_expected(st);
  check_stream("trapping store");
  drive_record(ld);
  end_records();
  add_expected(ld);
  check_stream("load");
endtask

// Ready is high three cycles in four, so the buffer keeps up at eight-cycle spacing
task automatic random_ready_stream();
  tb_rec_t     r;
  int unsigned cyc;
  int unsigned n;
  n = 0;
  for (cyc = 0; cyc < 160; cyc++) begin
    @(posedge clk_i);
    trace_ready_i <= (($urandom % 4) != 0);
    if ((cyc % 8) == 0) begin
      r = make_rec(trace_pkg::order_t'(100 + n), 5'($urandom % 32), $urandom % 3,
                   (($urandom % 8) == 0));
      set_record(r);
      add_expected(r);
      n++;
    end else begin
      rvfi_valid_i <= 1'b0;
    end
  end
  @(posedge clk_i);
  trace_ready_i <= 1'b1;
  check_stream("random ready");
endtask

task automatic overflow_loss();
  tb_rec_t kept[5];
  tb_rec_t r;
  int      i;
  @(posedge clk_i);
  trace_ready_i <= 1'b0;
  for (i = 0; i < 10; i++) begin
    r = make_rec(trace_pkg::order_t'(i), ((i % 2) == 1) ? 5'(i + 1) : 5'd0, i % 3, 1'b0);
    drive_record(r);
    if (i < 5) begin
      kept[i] = r;
    end
  end
  end_records();
  repeat (3) @(posedge clk_i);
  trace_ready_i <= 1'b1;
  // Packer holds order 0, the buffer holds orders 1 to 4
  add_expected(kept[0]);
  add_expected_loss(8'd5);
  for (i = 1; i < 5; i++) begin
    add_expected(kept[i]);
  end
  check_stream("overflow");
endtask

// ==== tb_trace_top.sv ====
// Retirement trace testbench
// Plays the core on the retirement port and collects every transferred stream word

`timescale 1ns/10ps

module tb_trace_top;

  typedef struct packed {
    trace_pkg::order_t    order;
    trace_pkg::word_t     insn;
    logic                 trap;
    trace_pkg::reg_addr_t rd_addr;
    trace_pkg::word_t     rd_wdata;
    trace_pkg::word_t     pc;
    trace_pkg::word_t     mem_addr;
    trace_pkg::mem_mask_t rmask;
    trace_pkg::mem_mask_t wmask;
  } tb_rec_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 rvfi_valid_i;
  trace_pkg::order_t    rvfi_order_i;
  trace_pkg::word_t     rvfi_insn_i;
  logic                 rvfi_trap_i;
  trace_pkg::reg_addr_t rvfi_rd_addr_i;
  trace_pkg::word_t     rvfi_rd_wdata_i;
  trace_pkg::word_t     rvfi_pc_rdata_i;
  trace_pkg::word_t     rvfi_mem_addr_i;
  trace_pkg::mem_mask_t rvfi_mem_rmask_i;
  trace_pkg::mem_mask_t rvfi_mem_wmask_i;
  logic                 trace_ready_i;
  logic                 trace_valid_o;
  trace_pkg::word_t     trace_data_o;

  trace_pkg::word_t     got_q[$];
  trace_pkg::word_t     exp_q[$];
  int unsigned          errors;
  int unsigned          checks;

  trace_top i_dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .rvfi_valid_i     (rvfi_valid_i),
    .rvfi_order_i     (rvfi_order_i),
    .rvfi_insn_i      (rvfi_insn_i),
    .rvfi_trap_i      (rvfi_trap_i),
    .rvfi_rd_addr_i   (rvfi_rd_addr_i),
    .rvfi_rd_wdata_i  (rvfi_rd_wdata_i),
    .rvfi_pc_rdata_i  (rvfi_pc_rdata_i),
    .rvfi_mem_addr_i  (rvfi_mem_addr_i),
    .rvfi_mem_rmask_i (rvfi_mem_rmask_i),
    .rvfi_mem_wmask_i (rvfi_mem_wmask_i),
    .trace_ready_i    (trace_ready_i),
    .trace_valid_o    (trace_valid_o),
    .trace_data_o     (trace_data_o)
  );

  always #5 clk_i = ~clk_i;

  // Collector samples the stream at the edge where a word transfers
  always @(posedge clk_i) begin
    if (trace_valid_o && trace_ready_i) begin
      got_q.push_back(trace_data_o);
    end
  end

  `include "tb_trace_tasks.svh"

  initial begin
    void'($urandom(32'h7b11_03f8));
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    rvfi_valid_i     = 1'b0;
    rvfi_order_i     = '0;
    rvfi_insn_i      = '0;
    rvfi_trap_i      = 1'b0;
    rvfi_rd_addr_i   = '0;
    rvfi_rd_wdata_i  = '0;
    rvfi_pc_rdata_i  = '0;
    rvfi_mem_addr_i  = '0;
    rvfi_mem_rmask_i = '0;
    rvfi_mem_wmask_i = '0;
    trace_ready_i    = 1'b1;
    errors           = 0;
    checks           = 0;

    quiet_after_reset();
    single_rd_packet();
    store_load_packets();
    random_ready_stream();
    overflow_loss();

    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== trace_emit_fsm.sv ====
// Packet emitter FSM
// Walks each packet word by word and handles the trace stream handshake

`timescale 1ns/10ps

module trace_emit_fsm (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   fifo_empty_i,
  input  logic                   loss_pending_i,
  input  logic                   has_rd_i,
  input  logic                   has_mem_i,
  input  logic                   trace_ready_i,
  output logic                   pop_o,
  output logic                   loss_clear_o,
  output logic                   trace_valid_o,
  output trace_pkg::emit_state_e state_o
);

  trace_pkg::emit_state_e state_q;
  trace_pkg::emit_state_e state_d;
  logic                   xfer;

  assign trace_valid_o = (state_q != trace_pkg::IDLE);
  assign xfer          = trace_valid_o && trace_ready_i;

  // Loss report goes out before the next record
  assign pop_o        = (state_q == trace_pkg::IDLE) && !loss_pending_i && !fifo_empty_i;
  assign loss_clear_o = (state_q == trace_pkg::LOSS) && trace_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      trace_pkg::IDLE: begin
        if (loss_pending_i) begin
          state_d = trace_pkg::LOSS;
        end else if (!fifo_empty_i) begin
          state_d = trace_pkg::HEAD;
        end
      end
      trace_pkg::HEAD: begin
        if (xfer) begin
          state_d = trace_pkg::PC;
        end
      end
      trace_pkg::PC: begin
        if (xfer) begin
          state_d = trace_pkg::INSN;
        end
      end
      trace_pkg::INSN: begin
        if (xfer) begin
          if (has_rd_i) begin
            state_d = trace_pkg::RD;
          end else if (has_mem_i) begin
            state_d = trace_pkg::MEM;
          end else begin
            state_d = trace_pkg::IDLE;
          end
        end
      end
      trace_pkg::RD: begin
        if (xfer) begin
          state_d = has_mem_i ? trace_pkg::MEM : trace_pkg::IDLE;
        end
      end
      trace_pkg::MEM, trace_pkg::LOSS: begin
        if (xfer) begin
          state_d = trace_pkg::IDLE;
        end
      end
      default: state_d = trace_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= trace_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // Stalled word stays in place
  a_stall_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    trace_valid_o && !trace_ready_i |=> $stable(state_q)
  );

endmodule

// ==== trace_loss_counter.sv ====
// Loss counter
// Saturating count of records dropped since the last loss packet

`timescale 1ns/10ps

module trace_loss_counter (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 drop_i,
  input  logic                 clear_i,
  output trace_pkg::loss_cnt_t loss_cnt_o,
  output logic                 loss_pending_o
);

  trace_pkg::loss_cnt_t cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      // Drop in the clearing cycle starts the next count
      cnt_q <= drop_i ? trace_pkg::loss_cnt_t'(1) : '0;
    end else if (drop_i && (cnt_q != '1)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign loss_cnt_o     = cnt_q;
  assign loss_pending_o = (cnt_q != '0);

  // Saturates at 255
  a_no_wrap: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cnt_q == '1) && drop_i && !clear_i |=> (cnt_q == '1)
  );

endmodule

// ==== trace_packer.sv ====
// Packet word former
// Holds the record in flight and builds the stream word for each emitter state

`timescale 1ns/10ps

module trace_packer (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   load_i,
  input  trace_pkg::rec_t        rec_i,
  input  trace_pkg::emit_state_e state_i,
  input  trace_pkg::loss_cnt_t   loss_cnt_i,
  output logic                   has_rd_o,
  output logic                   has_mem_o,
  output trace_pkg::word_t       word_o
);

  trace_pkg::rec_t        rec_q;
  trace_pkg::order_t      order;
  trace_pkg::word_t       insn;
  logic                   trap;
  trace_pkg::reg_addr_t   rd_addr;
  trace_pkg::word_t       rd_wdata;
  trace_pkg::word_t       pc;
  trace_pkg::word_t       mem_addr;
  trace_pkg::mem_mask_t   rmask;
  trace_pkg::mem_mask_t   wmask;
  logic                   mem_write;
  trace_pkg::word_t       head_word;
  trace_pkg::word_t       loss_word;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rec_q <= '0;
    end else if (load_i) begin
      rec_q <= rec_i;
    end
  end

  // Same field order as the packing in the top level
  assign {order, insn, trap, rd_addr, rd_wdata, pc, mem_addr, rmask, wmask} = rec_q;

  assign has_rd_o  = (rd_addr != '0);
  assign has_mem_o = (rmask != '0) || (wmask != '0);
  assign mem_write = (wmask != '0);

  assign head_word = {trace_pkg::KIND_RETIRE, trap, has_rd_o, has_mem_o, mem_write,
                      3'b000, rd_addr, order[15:0]};

  // Count is 8 bits in the low byte
  assign loss_word = {trace_pkg::KIND_LOSS, 20'h0_0000, loss_cnt_i};

  always_comb begin
    case (state_i)
      trace_pkg::HEAD: word_o = head_word;
      trace_pkg::PC:   word_o = pc;
      trace_pkg::INSN: word_o = insn;
      trace_pkg::RD:   word_o = rd_wdata;
      trace_pkg::MEM:  word_o = mem_addr;
      trace_pkg::LOSS: word_o = loss_word;
      default:         word_o = '0;
    endcase
  end

endmodule

// ==== trace_pkg.sv ====
// Retirement trace definitions
// Record field widths, packet kind codes, buffer depth and emitter states

package trace_pkg;

  // Stream word and 32-bit architectural values
  typedef logic [31:0] word_t;

  // Retirement sequence number
  typedef logic [63:0] order_t;

  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] mem_mask_t;

  // Dropped records since the last loss packet
  typedef logic [7:0] loss_cnt_t;

  // Buffer fill level, 0 to FIFO_DEPTH
  typedef logic [2:0] fifo_cnt_t;

  localparam int unsigned FIFO_DEPTH = 4;

  // Header kind codes, bits 31:28 of the first word
  localparam logic [3:0] KIND_RETIRE = 4'h1;
  localparam logic [3:0] KIND_LOSS   = 4'h2;

  // Packed record: order, insn, trap, rd_addr, rd_wdata, pc, mem_addr, rmask, wmask
  localparam int unsigned REC_W = $bits(order_t) + $bits(word_t) + 1 + $bits(reg_addr_t) +
                                  3 * $bits(word_t) + 2 * $bits(mem_mask_t);

  typedef logic [REC_W-1:0] rec_t;

  typedef enum logic [2:0] {
    IDLE = 3'd0,
    HEAD = 3'd1,
    PC   = 3'd2,
    INSN = 3'd3,
    RD   = 3'd4,
    MEM  = 3'd5,
    LOSS = 3'd6
  } emit_state_e;

endpackage

// ==== trace_record_fifo.sv ====
// Record buffer
// Circular buffer of retired-instruction records with full and empty status

`timescale 1ns/10ps

module trace_record_fifo (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              push_i,
  input  trace_pkg::rec_t   push_data_i,
  input  logic              pop_i,
  output trace_pkg::rec_t   pop_data_o,
  output logic              empty_o,
  output logic              full_o
);

  localparam int unsigned PTR_W = $clog2(trace_pkg::FIFO_DEPTH);

  trace_pkg::rec_t      mem_q [trace_pkg::FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  trace_pkg::fifo_cnt_t cnt_q;
  logic                 push_ok;
  logic                 pop_ok;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == trace_pkg::fifo_cnt_t'(trace_pkg::FIFO_DEPTH));

  // A push on a full buffer is lost, even with a pop in the same cycle
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Emitter only pops when a record is waiting
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o
  );

  a_cnt_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) cnt_q <= trace_pkg::FIFO_DEPTH
  );

endmodule

// ==== trace_top.sv ====
// Retirement trace top level
// Buffers retirement records and emits them as packets on a valid/ready stream

`timescale 1ns/10ps

module trace_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Retirement port, no back-pressure
  input  logic                 rvfi_valid_i,
  input  trace_pkg::order_t    rvfi_order_i,
  input  trace_pkg::word_t     rvfi_insn_i,
  input  logic                 rvfi_trap_i,
  input  trace_pkg::reg_addr_t rvfi_rd_addr_i,
  input  trace_pkg::word_t     rvfi_rd_wdata_i,
  input  trace_pkg::word_t     rvfi_pc_rdata_i,
  input  trace_pkg::word_t     rvfi_mem_addr_i,
  input  trace_pkg::mem_mask_t rvfi_mem_rmask_i,
  input  trace_pkg::mem_mask_t rvfi_mem_wmask_i,

  // Trace stream
  input  logic                 trace_ready_i,
  output logic                 trace_valid_o,
  output trace_pkg::word_t     trace_data_o
);

  trace_pkg::rec_t        push_rec;
  trace_pkg::rec_t        head_rec;
  logic                   fifo_empty;
  logic                   fifo_full;
  logic                   pop;
  logic                   drop;
  logic                   loss_clear;
  logic                   loss_pending;
  trace_pkg::loss_cnt_t   loss_cnt;
  logic                   has_rd;
  logic                   has_mem;
  trace_pkg::emit_state_e state;

  assign push_rec = {rvfi_order_i, rvfi_insn_i, rvfi_trap_i, rvfi_rd_addr_i,
                     rvfi_rd_wdata_i, rvfi_pc_rdata_i, rvfi_mem_addr_i,
                     rvfi_mem_rmask_i, rvfi_mem_wmask_i};

  assign drop = rvfi_valid_i && fifo_full;

  trace_record_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (rvfi_valid_i),
    .push_data_i (push_rec),
    .pop_i       (pop),
    .pop_data_o  (head_rec),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full)
  );

  trace_loss_counter u_loss (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .drop_i         (drop),
    .clear_i        (loss_clear),
    .loss_cnt_o     (loss_cnt),
    .loss_pending_o (loss_pending)
  );

  trace_emit_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fifo_empty_i   (fifo_empty),
    .loss_pending_i (loss_pending),
    .has_rd_i       (has_rd),
    .has_mem_i      (has_mem),
    .trace_ready_i  (trace_ready_i),
    .pop_o          (pop),
    .loss_clear_o   (loss_clear),
    .trace_valid_o  (trace_valid_o),
    .state_o        (state)
  );

  trace_packer u_packer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .load_i     (pop),
    .rec_i      (head_rec),
    .state_i    (state),
    .loss_cnt_i (loss_cnt),
    .has_rd_o   (has_rd),
    .has_mem_o  (has_mem),
    .word_o     (trace_data_o)
  );

endmodule
